// ==== Makefile ====
# Verilator build and run of the decode stage testbench
TOP = decodeStageTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --timescale 1ns/1ps -f mipsDecode.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

// ==== mipsDecode.f ====
+incdir+src
src/decodePkg.sv
src/regFile.sv
src/controlDecoder.sv
src/branchResolve.sv
src/idExLatch.sv
src/decodeStage.sv
sim/decodeStageTb.sv

// ==== sim/decodeStageTb.sv ====
/*
 * testbench for the decode stage that loads the register file and then
 * runs a table of instructions through it checking ex and redirect
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb import decodePkg::*; ;

	localparam int period = 100;
	localparam word_t basePc = 32'h0040_0100; // address after the instruction
	localparam word_t highPc = 32'hB000_0200; // top nibble kept by J and JAL
	localparam word_t jTarget = 32'hB001_1580; // index 0x0004560 under the B nibble
	localparam word_t minusThree = 32'hFFFF_FFFD;
	localparam word_t jrBase = 32'h0000_1000;
	// {aluSrc, memRead, memWrite, memToReg, regWrite}
	localparam logic [4:0] flagsAlu = 5'b00001;
	localparam logic [4:0] flagsImm = 5'b10001;
	localparam logic [4:0] flagsLoad = 5'b11011;
	localparam logic [4:0] flagsStore = 5'b10100;

	logic CLK;
	logic RESET;
	logic freeze;
	logic bubble;
	word_t instr;
	word_t pc;
	wbReq_t wb;
	exBundle_t ex;
	redirect_t redirect;

	int exErrors = 0;
	int redirectErrors = 0;

	// stimulus table
	string names[$];
	word_t instrs[$];
	word_t pcs[$];
	logic [1:0] holds[$]; // {freeze, bubble}
	exBundle_t expEx[$];
	redirect_t expRd[$];

	decodeStage dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.instr(instr),
		.pc(pc),
		.freeze(freeze),
		.bubble(bubble),
		.wb(wb),
		.ex(ex),
		.redirect(redirect)
	);

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic word_t seedValue(input int idx);
		case (idx)
			1, 3: return 32'd5;
			2: return minusThree;
			4: return jrBase;
			default: return {16'hC0DE, 11'd0, idx[4:0]}; // unique per register
		endcase
	endfunction

	function automatic word_t rTypeWord(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd,
			input regIdx_t sa, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t iTypeWord(input logic [5:0] op, input regIdx_t rs, input regIdx_t rt,
			input imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic exBundle_t exFields(input word_t opA, input word_t opB, input regIdx_t rs,
			input regIdx_t rt, input regIdx_t dest, input aluOp_t op, input logic [4:0] flags);
		exBundle_t b;
		b = '0;
		b.operandA = opA;
		b.operandB = opB;
		b.rs = rs;
		b.rt = rt;
		b.dest = dest;
		b.aluOp = op;
		{b.aluSrc, b.memRead, b.memWrite, b.memToReg, b.regWrite} = flags;
		return b;
	endfunction

	function automatic redirect_t redirectTo(input logic taken, input word_t target);
		return {taken, target};
	endfunction

	// plain decode entries take imm and shamt straight from the word
	task automatic tableEntry(input string name, input word_t word, input word_t addr,
			input logic [1:0] hold, input exBundle_t expected, input redirect_t target);
		exBundle_t e;
		e = expected;
		if (hold == 2'b00) begin
			e.imm = word[15:0];
			e.shamt = word[10:6];
		end
		names.push_back(name);
		instrs.push_back(word);
		pcs.push_back(addr);
		holds.push_back(hold);
		expEx.push_back(e);
		expRd.push_back(target);
	endtask

	task automatic fallingEdges(input int n);
		realtime start;
		int seen;
		seen = 0;
		while (seen < n) begin
			start = $realtime;
			fork
				@(negedge CLK);
				#(2 * period);
			join_any
			disable fork;
			if ($realtime - start >= 2 * period) begin
				$display("timeout: no falling clock edge within %0d ns", 2 * period);
				$display("test failed");
				$finish;
			end else begin
				seen++;
			end
		end
	endtask

	task automatic compareEx(input string name, input exBundle_t expected, input exBundle_t actual);
		if (actual !== expected) begin
			exErrors++;
			$display("error %s: ex expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic verifyRedirect(input string name, input redirect_t expected,
			input redirect_t actual);
		if (actual !== expected) begin
			redirectErrors++;
			$display("error %s: redirect expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ----------------------------------------------------------------------
	// table
	// ----------------------------------------------------------------------
	initial begin
		tableEntry("read r0", rTypeWord(0, 1, 6, 0, 6'h20), basePc, 2'b00,
			exFields(0, 5, 0, 1, 6, aluAdd, flagsAlu), redirectTo(0, basePc));
		tableEntry("add", rTypeWord(1, 2, 7, 0, 6'h20), basePc, 2'b00,
			exFields(5, minusThree, 1, 2, 7, aluAdd, flagsAlu), redirectTo(0, basePc));
		tableEntry("sub", rTypeWord(3, 1, 8, 0, 6'h22), basePc, 2'b00,
			exFields(5, 5, 3, 1, 8, aluSub, flagsAlu), redirectTo(0, basePc));
		tableEntry("slt", rTypeWord(2, 1, 9, 0, 6'h2A), basePc, 2'b00,
			exFields(minusThree, 5, 2, 1, 9, aluSlt, flagsAlu), redirectTo(0, basePc));
		tableEntry("sra", rTypeWord(0, 2, 10, 4, 6'h03), basePc, 2'b00,
			exFields(0, minusThree, 0, 2, 10, aluSra, flagsAlu), redirectTo(0, basePc));
		tableEntry("addi", iTypeWord(6'h08, 1, 11, 16'hFFF8), basePc, 2'b00,
			exFields(5, seedValue(11), 1, 0, 11, aluAdd, flagsImm), redirectTo(0, basePc));
		tableEntry("lui", iTypeWord(6'h0F, 0, 12, 16'h1234), basePc, 2'b00,
			exFields(0, seedValue(12), 0, 0, 12, aluLui, flagsImm), redirectTo(0, basePc));
		tableEntry("lw", iTypeWord(6'h23, 4, 13, 16'h0008), basePc, 2'b00,
			exFields(jrBase, seedValue(13), 4, 0, 13, aluAdd, flagsLoad), redirectTo(0, basePc));
		tableEntry("sw", iTypeWord(6'h2B, 4, 1, 16'hFFFC), basePc, 2'b00,
			exFields(jrBase, 5, 4, 0, 1, aluAdd, flagsStore), redirectTo(0, basePc));

		// each branch condition taken then not taken
		tableEntry("beq taken", iTypeWord(6'h04, 1, 3, 16'h0010), basePc, 2'b00,
			exFields(5, 5, 1, 3, 3, aluNone, 0), redirectTo(1, basePc + 32'h40));
		tableEntry("beq not taken", iTypeWord(6'h04, 1, 2, 16'h0010), basePc, 2'b00,
			exFields(5, minusThree, 1, 2, 2, aluNone, 0), redirectTo(0, basePc));
		tableEntry("bne taken", iTypeWord(6'h05, 1, 2, 16'hFFFC), basePc, 2'b00,
			exFields(5, minusThree, 1, 2, 2, aluNone, 0), redirectTo(1, basePc - 32'h10));
		tableEntry("bne not taken", iTypeWord(6'h05, 1, 3, 16'h0010), basePc, 2'b00,
			exFields(5, 5, 1, 3, 3, aluNone, 0), redirectTo(0, basePc));
		tableEntry("blez taken", iTypeWord(6'h06, 2, 0, 16'h0020), basePc, 2'b00,
			exFields(minusThree, 0, 2, 0, 0, aluNone, 0), redirectTo(1, basePc + 32'h80));
		tableEntry("blez not taken", iTypeWord(6'h06, 1, 0, 16'h0020), basePc, 2'b00,
			exFields(5, 0, 1, 0, 0, aluNone, 0), redirectTo(0, basePc));
		tableEntry("bgtz taken", iTypeWord(6'h07, 1, 0, 16'hFFF0), basePc, 2'b00,
			exFields(5, 0, 1, 0, 0, aluNone, 0), redirectTo(1, basePc - 32'h40));
		tableEntry("bgtz not taken", iTypeWord(6'h07, 2, 0, 16'hFFF0), basePc, 2'b00,
			exFields(minusThree, 0, 2, 0, 0, aluNone, 0), redirectTo(0, basePc));
		tableEntry("bltz taken", iTypeWord(6'h01, 2, 0, 16'h0004), basePc, 2'b00,
			exFields(minusThree, 0, 2, 0, 0, aluNone, 0), redirectTo(1, basePc + 32'h10));
		tableEntry("bltz not taken", iTypeWord(6'h01, 1, 0, 16'h0004), basePc, 2'b00,
			exFields(5, 0, 1, 0, 0, aluNone, 0), redirectTo(0, basePc));
		tableEntry("bgez taken", iTypeWord(6'h01, 1, 1, 16'h0008), basePc, 2'b00,
			exFields(5, 5, 1, 1, 1, aluNone, 0), redirectTo(1, basePc + 32'h20));
		tableEntry("bgez not taken", iTypeWord(6'h01, 2, 1, 16'h0008), basePc, 2'b00,
			exFields(minusThree, 5, 2, 1, 1, aluNone, 0), redirectTo(0, basePc));

		// jumps
		tableEntry("j", {6'h02, 26'h0004560}, highPc, 2'b00, exFields(0, 0, 0, 0, 0, aluNone, 0),
			redirectTo(1, jTarget));
		tableEntry("jal", {6'h03, 26'h0004560}, highPc, 2'b00,
			exFields(highPc, 4, 0, 0, 31, aluAddu, flagsAlu), redirectTo(1, jTarget));
		tableEntry("jr", rTypeWord(4, 0, 0, 0, 6'h08), highPc, 2'b00,
			exFields(jrBase, 0, 4, 0, 0, aluNone, 0), redirectTo(1, jrBase));
		tableEntry("jalr", rTypeWord(4, 0, 20, 0, 6'h09), highPc, 2'b00,
			exFields(highPc, 4, 0, 0, 20, aluAddu, flagsAlu), redirectTo(1, jrBase));

		// freeze keeps the jalr result while instr moves on
		tableEntry("freeze first", rTypeWord(3, 1, 8, 0, 6'h22), basePc, 2'b10, expEx[$], expRd[$]);
		tableEntry("freeze second", iTypeWord(6'h23, 4, 13, 16'h0008), basePc, 2'b10,
			expEx[$], expRd[$]);
		tableEntry("bubble over freeze", rTypeWord(1, 2, 7, 0, 6'h20), basePc, 2'b11, '0, '0);
		tableEntry("undefined opcode", 32'hFC00_0000, basePc, 2'b00,
			exFields(0, 0, 0, 0, 0, aluNone, 0), redirectTo(0, basePc));
	end

	// ----------------------------------------------------------------------
	// run
	// ----------------------------------------------------------------------
	initial begin
		RESET = 1'b0;
		freeze = 1'b0;
		bubble = 1'b0;
		instr = '0;
		pc = '0;
		wb = '0;
		fallingEdges(4);
		compareEx("reset", '0, ex);
		verifyRedirect("reset", '0, redirect);
		RESET = 1'b1;

		// load every register including r0 which must drop its value
		for (int i = 0; i < 32; i++) begin
			wb.enable = 1'b1;
			wb.index = i[4:0];
			wb.data = (i == 0) ? 32'hDEAD_BEEF : seedValue(i);
			fallingEdges(1);
		end
		wb = '0;

		for (int k = 0; k < names.size(); k++) begin
			instr = instrs[k];
			pc = pcs[k];
			{freeze, bubble} = holds[k];
			fallingEdges(1); // result registered on the rising edge between
			compareEx(names[k], expEx[k], ex);
			verifyRedirect(names[k], expRd[k], redirect);
		end

		$display("entries %0d, ex errors %0d, redirect errors %0d", names.size(), exErrors,
			redirectErrors);
		if (exErrors == 0 && redirectErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/branchResolve.sv ====
/*
 * branch resolver: condition compare and next-pc target selection
 */
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module branchResolve import decodePkg::*; (
	input wire ctrl_t ctrl,
	input wire word_t instr,
	input wire word_t pc, // address after the instruction
	input wire word_t rsData,
	input wire word_t rtData,
	output redirect_t nextRedirect
);

	word_t branchOffset;
	word_t jumpTarget;
	logic rsNeg;
	logic rsZero;
	logic condMet;

	// sign-extended immediate, word aligned
	assign branchOffset = {{(`DATA_WIDTH-`IMM_WIDTH-2){instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

	// signed compares against zero only need sign and zero tests
	assign rsNeg = rsData[`DATA_WIDTH-1];
	assign rsZero = (rsData == '0);

	always_comb begin
		case (ctrl.branchCond)
			condEq: condMet = (rsData == rtData);
			condNe: condMet = (rsData != rtData);
			condLez: condMet = rsNeg || rsZero;
			condGtz: condMet = !rsNeg && !rsZero;
			condLtz: condMet = rsNeg;
			condGez: condMet = !rsNeg;
			default: condMet = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// redirect
	// ----------------------------------------------------------------------
	assign nextRedirect.taken = ctrl.jump || ctrl.jumpReg || condMet;

	always_comb begin
		if (ctrl.jumpReg) begin
			nextRedirect.target = rsData;
		end else if (ctrl.jump) begin
			nextRedirect.target = jumpTarget;
		end else if (condMet) begin
			nextRedirect.target = pc + branchOffset;
		end else begin
			nextRedirect.target = pc; // fall through
		end
	end

endmodule

`default_nettype wire

// ==== src/controlDecoder.sv ====
/*
 * control decoder: opcode, funct and rt fields to control fields;
 * unknown patterns give the all-zero control word
 */
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module controlDecoder import decodePkg::*; (
	input wire word_t instr,
	output ctrl_t ctrl
);

	logic [`OPCODE_WIDTH-1:0] opcode;
	logic [`OPCODE_WIDTH-1:0] funct;
	regIdx_t rtField;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rtField = instr[20:16];

	always_comb begin
		ctrl = '0;
		case (opcode)
			// --------------------------------------------------------------
			// SPECIAL, selected by funct
			// --------------------------------------------------------------
			6'b000000: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					6'b000000: ctrl.aluOp = aluSll; // also nop
					6'b000010: ctrl.aluOp = aluSrl;
					6'b000011: ctrl.aluOp = aluSra;
					6'b000100: ctrl.aluOp = aluSllv;
					6'b000110: ctrl.aluOp = aluSrlv;
					6'b000111: ctrl.aluOp = aluSrav;
					6'b001000: begin // jr
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
					end
					6'b001001: begin // jalr, link value into rd
						ctrl.jumpReg = 1'b1;
						ctrl.link = 1'b1;
						ctrl.aluOp = aluAddu;
					end
					6'b100000: ctrl.aluOp = aluAdd;
					6'b100001: ctrl.aluOp = aluAddu;
					6'b100010: ctrl.aluOp = aluSub;
					6'b100011: ctrl.aluOp = aluSubu;
					6'b100100: ctrl.aluOp = aluAnd;
					6'b100101: ctrl.aluOp = aluOr;
					6'b100110: ctrl.aluOp = aluXor;
					6'b100111: ctrl.aluOp = aluNor;
					6'b101010: ctrl.aluOp = aluSlt;
					6'b101011: ctrl.aluOp = aluSltu;
					default: ctrl = '0;
				endcase
			end

			// REGIMM, selected by rt
			6'b000001: begin
				case (rtField)
					5'b00000: ctrl.branchCond = condLtz;
					5'b00001: ctrl.branchCond = condGez;
					default: ctrl = '0;
				endcase
			end

			// --------------------------------------------------------------
			// jumps and branches
			// --------------------------------------------------------------
			6'b000010: ctrl.jump = 1'b1; // j
			6'b000011: begin // jal
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluAddu;
			end
			6'b000100: ctrl.branchCond = condEq;
			6'b000101: ctrl.branchCond = condNe;
			6'b000110: ctrl.branchCond = condLez;
			6'b000111: ctrl.branchCond = condGtz;

			// immediate forms, op picked by the low opcode bits
			6'b001000, 6'b001001, 6'b001010, 6'b001011,
			6'b001100, 6'b001101, 6'b001110, 6'b001111: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				case (opcode[2:0])
					3'b000: ctrl.aluOp = aluAdd;
					3'b001: ctrl.aluOp = aluAddu;
					3'b010: ctrl.aluOp = aluSlt;
					3'b011: ctrl.aluOp = aluSltu;
					3'b100: ctrl.aluOp = aluAnd;
					3'b101: ctrl.aluOp = aluOr;
					3'b110: ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluLui;
				endcase
			end

			// --------------------------------------------------------------
			// memory access, address is base + offset
			// --------------------------------------------------------------
			6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1; // write-back requested via memToReg
			end
			6'b101000, 6'b101001, 6'b101011: begin // sb, sh, sw
				ctrl.aluOp = aluAdd;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end

			default: ctrl = '0; // illegal, passes on as a bubble
		endcase
	end

endmodule

`default_nettype wire

// ==== src/decodePkg.sv ====
/*
 * decode package: word and index types, ALU and branch encodings,
 * and the structs passed between the decode blocks
 */
`default_nettype none
`include "decode_defines.svh"

package decodePkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regIdx_t; // also a shift amount
	typedef logic [`IMM_WIDTH-1:0] imm_t;

	// ----------------------------------------------------------------------
	// encodings
	// ----------------------------------------------------------------------
	typedef enum logic [4:0] {
		aluNone = 5'd0, // bubble / no operation
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluSllv,
		aluSrlv,
		aluSrav,
		aluLui
	} aluOp_t;

	typedef enum logic [2:0] {
		condNone = 3'd0,
		condEq,
		condNe,
		condLez,
		condGtz,
		condLtz,
		condGez
	} branchCond_t;

	// ----------------------------------------------------------------------
	// bundles
	// ----------------------------------------------------------------------
	typedef struct packed {
		aluOp_t aluOp;
		branchCond_t branchCond;
		logic regDst; // destination is rd
		logic link;
		logic jump; // J / JAL
		logic jumpReg; // JR / JALR
		logic aluSrc; // operand B from the immediate
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
	} ctrl_t;

	typedef struct packed {
		logic enable;
		regIdx_t index;
		word_t data;
	} wbReq_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		word_t operandA;
		word_t operandB;
		imm_t imm;
		regIdx_t shamt;
		regIdx_t rs; // forwarding index, zero if unused
		regIdx_t rt;
		regIdx_t dest;
		aluOp_t aluOp;
		logic aluSrc;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
	} exBundle_t;

endpackage

`default_nettype wire

// ==== src/decodeStage.sv ====
/*
 * MIPS instruction decode stage: register read, control decode,
 * branch resolution and the ID/EX register
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; (
	input wire CLK,
	input wire RESET,
	input wire word_t instr,
	input wire word_t pc,
	input wire freeze,
	input wire bubble,
	input wire wbReq_t wb,
	output exBundle_t ex,
	output redirect_t redirect
);

	word_t rsData;
	word_t rtData;
	ctrl_t ctrl;
	redirect_t nextRedirect;

	regFile regFile_i (
		.CLK(CLK),
		.wb(wb),
		.rsIdx(instr[25:21]),
		.rtIdx(instr[20:16]),
		.rsData(rsData),
		.rtData(rtData)
	);

	controlDecoder controlDecoder_i (
		.instr(instr),
		.ctrl(ctrl)
	);

	branchResolve branchResolve_i (
		.ctrl(ctrl),
		.instr(instr),
		.pc(pc),
		.rsData(rsData),
		.rtData(rtData),
		.nextRedirect(nextRedirect)
	);

	idExLatch idExLatch_i (
		.CLK(CLK),
		.RESET(RESET),
		.freeze(freeze),
		.bubble(bubble),
		.instr(instr),
		.pc(pc),
		.ctrl(ctrl),
		.rsData(rsData),
		.rtData(rtData),
		.nextRedirect(nextRedirect),
		.ex(ex),
		.redirect(redirect)
	);

endmodule

`default_nettype wire

// ==== src/decode_defines.svh ====
/*
 * MIPS decode stage widths and fixed register constants
 */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define OPCODE_WIDTH 6
`define IMM_WIDTH 16

// ----------------------------------------------------------------------
// register file
// ----------------------------------------------------------------------
`define REG_COUNT 32

// return address register of JAL
`define LINK_REG 31

// added to the sequential pc for the link value
`define LINK_OFFSET 4

`endif

// ==== src/idExLatch.sv ====
/*
 * ID/EX pipe register with operand steering, freeze (hold) and
 * bubble (clear); bubble has priority over freeze
 */
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module idExLatch import decodePkg::*; (
	input wire CLK,
	input wire RESET,
	input wire freeze,
	input wire bubble,
	input wire word_t instr,
	input wire word_t pc,
	input wire ctrl_t ctrl,
	input wire word_t rsData,
	input wire word_t rtData,
	input wire redirect_t nextRedirect,
	output exBundle_t ex,
	output redirect_t redirect
);

	exBundle_t nextEx;

	// ----------------------------------------------------------------------
	// operand steering
	// ----------------------------------------------------------------------
	always_comb begin
		nextEx = '0;
		nextEx.imm = instr[15:0];
		nextEx.shamt = instr[10:6];
		nextEx.aluOp = ctrl.aluOp;
		nextEx.aluSrc = ctrl.aluSrc;
		nextEx.memRead = ctrl.memRead;
		nextEx.memWrite = ctrl.memWrite;
		nextEx.memToReg = ctrl.memToReg;
		nextEx.regWrite = ctrl.regWrite || ctrl.memToReg;

		if (ctrl.link) begin // return address = pc + 4, nothing to forward
			nextEx.operandA = pc;
			nextEx.operandB = word_t'(`LINK_OFFSET);
		end else begin
			nextEx.operandA = rsData;
			nextEx.operandB = rtData;
			nextEx.rs = instr[25:21];
			nextEx.rt = ctrl.aluSrc ? '0 : instr[20:16];
		end

		if (ctrl.regDst) begin
			nextEx.dest = instr[15:11];
		end else if (ctrl.link) begin
			nextEx.dest = regIdx_t'(`LINK_REG);
		end else begin
			nextEx.dest = instr[20:16];
		end
	end

	// ----------------------------------------------------------------------
	// pipe register
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			ex <= '0;
			redirect <= '0;
		end else if (bubble) begin
			ex <= '0;
			redirect <= '0;
		end else if (!freeze) begin
			ex <= nextEx;
			redirect <= nextRedirect;
		end
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
/*
 * register file, 32 x 32, two combinational read ports and one
 * write-back port; register 0 reads as zero
 */
`timescale 1ns/1ps
`default_nettype none
`include "decode_defines.svh"

module regFile import decodePkg::*; (
	input wire CLK,
	input wire wbReq_t wb,
	input wire regIdx_t rsIdx,
	input wire regIdx_t rtIdx,
	output word_t rsData,
	output word_t rtData
);

	word_t regs [`REG_COUNT]; // no reset, contents start undefined

	// write-back port
	always_ff @(posedge CLK) begin
		if (wb.enable && (wb.index != '0)) begin
			regs[wb.index] <= wb.data;
		end
	end

	// ----------------------------------------------------------------------
	// read ports
	// ----------------------------------------------------------------------
	// entry 0 is never written, so force the zero here
	assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
	assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

`default_nettype wire
